// File: logic/rv32_pkg.sv
package rv32_pkg;

    localparam int xlen = 32;                     // Data and address width.
    localparam logic [xlen-1:0] reset_pc = '0;    // Address of the first fetch.

    // Major opcodes of the supported subset.
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;      // Also carries the scrambled J-type immediate.
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_imm;      // Operand b comes from the immediate.
        logic       is_branch;
        logic       branch_ne;    // Set for BNE, clear for BEQ.
        logic       is_jal;
        logic [4:0] rd;
        logic       rd_write;
        logic [4:0] rs1;
        logic [4:0] rs2;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [xlen-1:0] value;
        logic [xlen-1:0] pc;
    } wb_trace_t;

    typedef enum logic [1:0] {
        step_fetch,
        step_exec,
        step_wb
    } step_e;

endpackage

// File: logic/rv32_control.sv
`timescale 1ns/10ps

module rv32_control (
    input  logic clk,
    input  logic rst_n,
    output logic fetch_en,
    output logic exec_en,
    output logic wb_en
);
    import rv32_pkg::*;

    step_e state;
    step_e state_next;

    always_comb begin
        case (state)
            step_fetch: state_next = step_exec;
            step_exec:  state_next = step_wb;
            step_wb:    state_next = step_fetch;    // Next instruction.
            default:    state_next = step_fetch;    // Recover from the unused code.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= step_fetch;
        end else begin
            state <= state_next;
        end
    end

    // One strobe per step, so exactly one is high in any cycle.
    always_comb begin
        fetch_en = (state == step_fetch);
        exec_en  = (state == step_exec);
        wb_en    = (state == step_wb);
    end

endmodule

// File: logic/rv32_pc.sv
`timescale 1ns/10ps

module rv32_pc (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_en,
    input  logic                     taken,
    input  logic [rv32_pkg::xlen-1:0] target,
    output logic [rv32_pkg::xlen-1:0] pc
);
    import rv32_pkg::*;

    logic [xlen-1:0] pc_next;

    always_comb begin
        pc_next = taken ? target : pc + xlen'(4);    // Jump or fall through.
    end

    // The PC only moves on the edge that ends writeback.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (wb_en) begin
            pc <= pc_next;
        end
    end

endmodule

// File: logic/rv32_decode.sv
`timescale 1ns/10ps

module rv32_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fetch_en,
    input  logic [rv32_pkg::xlen-1:0] imem_data,
    output rv32_pkg::ctrl_t           ctrl,
    output logic [rv32_pkg::xlen-1:0] imm
);
    import rv32_pkg::*;

    instr_u ir;

    // Shared funct3 map of the register and immediate ALU ops.
    function automatic alu_op_e funct3_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  funct3_op = alt ? alu_sub : alu_add;
            3'b001:  funct3_op = alu_sll;
            3'b010:  funct3_op = alu_slt;
            3'b100:  funct3_op = alu_xor;
            3'b101:  funct3_op = alu_srl;
            3'b110:  funct3_op = alu_or;
            3'b111:  funct3_op = alu_and;
            default: funct3_op = alu_add;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;    // Opcode zero decodes as a no-op.
        end else if (fetch_en) begin
            ir <= imem_data;
        end
    end

    always_comb begin
        ctrl      = '0;
        imm       = '0;
        ctrl.rd   = ir.r_fmt.rd;
        ctrl.rs1  = ir.r_fmt.rs1;
        ctrl.rs2  = ir.r_fmt.rs2;
        case (ir.r_fmt.opcode)
            op_reg: begin
                ctrl.alu_op   = funct3_op(ir.r_fmt.funct3, ir.r_fmt.funct7[5]);
                ctrl.rd_write = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op   = funct3_op(ir.i_fmt.funct3, 1'b0);
                ctrl.use_imm  = 1'b1;
                ctrl.rd_write = 1'b1;
                imm = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
            end
            op_lui: begin
                ctrl.alu_op   = alu_pass_b;
                ctrl.use_imm  = 1'b1;
                ctrl.rd_write = 1'b1;
                imm = {ir.u_fmt.imm, 12'b0};
            end
            op_branch: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = ir.b_fmt.funct3[0];    // funct3 001 is BNE.
                imm = {{19{ir.b_fmt.imm_12}}, ir.b_fmt.imm_12, ir.b_fmt.imm_11,
                       ir.b_fmt.imm_10_5, ir.b_fmt.imm_4_1, 1'b0};
            end
            op_jal: begin
                ctrl.is_jal   = 1'b1;
                ctrl.rd_write = 1'b1;
                imm = {{11{ir.u_fmt.imm[19]}}, ir.u_fmt.imm[19], ir.u_fmt.imm[7:0],
                       ir.u_fmt.imm[8], ir.u_fmt.imm[18:9], 1'b0};
            end
            default: begin
                ctrl.rd_write = 1'b0;    // Unknown opcodes retire as no-ops.
            end
        endcase
    end

endmodule

// File: logic/rv32_regfile.sv
`timescale 1ns/10ps

module rv32_regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [4:0]                rs1,
    input  logic [4:0]                rs2,
    output logic [rv32_pkg::xlen-1:0] rs1_value,
    output logic [rv32_pkg::xlen-1:0] rs2_value,
    input  logic                      wb_en,
    input  logic                      rd_write,
    input  logic [4:0]                rd,
    input  logic [rv32_pkg::xlen-1:0] rd_value
);
    import rv32_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && rd_write && rd != 5'd0) begin
            regs[rd] <= rd_value;    // Writes to x0 are dropped.
        end
    end

    always_comb begin
        rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
        rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];
    end

endmodule

// File: logic/rv32_alu.sv
`timescale 1ns/10ps

module rv32_alu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      exec_en,
    input  rv32_pkg::ctrl_t           ctrl,
    input  logic [rv32_pkg::xlen-1:0] pc,
    input  logic [rv32_pkg::xlen-1:0] imm,
    input  logic [rv32_pkg::xlen-1:0] rs1_value,
    input  logic [rv32_pkg::xlen-1:0] rs2_value,
    output logic [rv32_pkg::xlen-1:0] result,
    output logic [rv32_pkg::xlen-1:0] target,
    output logic                      taken
);
    import rv32_pkg::*;

    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic            taken_next;

    always_comb begin
        op_b = ctrl.use_imm ? imm : rs2_value;
        case (ctrl.alu_op)
            alu_sub:    alu_out = rs1_value - op_b;
            alu_and:    alu_out = rs1_value & op_b;
            alu_or:     alu_out = rs1_value | op_b;
            alu_xor:    alu_out = rs1_value ^ op_b;
            alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(rs1_value) < $signed(op_b)};
            alu_sll:    alu_out = rs1_value << op_b[4:0];
            alu_srl:    alu_out = rs1_value >> op_b[4:0];
            alu_pass_b: alu_out = op_b;    // LUI passes the upper immediate.
            default:    alu_out = rs1_value + op_b;
        endcase
        // BEQ takes on equality, BNE on its inverse.
        taken_next = ctrl.is_jal |
                     (ctrl.is_branch & ((rs1_value == rs2_value) ^ ctrl.branch_ne));
    end

    always_ff @(posedge clk) begin
        if (exec_en) begin
            result <= ctrl.is_jal ? pc + xlen'(4) : alu_out;    // JAL links pc plus four.
            target <= pc + imm;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taken <= 1'b0;
        end else if (exec_en) begin
            taken <= taken_next;
        end
    end

endmodule

// File: logic/rv32.sv
`timescale 1ns/10ps

module rv32 (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [rv32_pkg::xlen-1:0] imem_data,
    output logic [rv32_pkg::xlen-1:0] imem_addr,
    output rv32_pkg::wb_trace_t       trace,
    output logic [7:0]                leds
);
    import rv32_pkg::*;

    logic            fetch_en;
    logic            exec_en;
    logic            wb_en;
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic [xlen-1:0] result;
    logic [xlen-1:0] target;
    logic            taken;
    logic            retire_write;

    rv32_control control_unit (
        .clk(clk), .rst_n(rst_n),
        .fetch_en(fetch_en), .exec_en(exec_en), .wb_en(wb_en)
    );

    rv32_pc pc_unit (
        .clk(clk), .rst_n(rst_n),
        .wb_en(wb_en), .taken(taken), .target(target), .pc(pc)
    );

    rv32_decode decode_unit (
        .clk(clk), .rst_n(rst_n),
        .fetch_en(fetch_en), .imem_data(imem_data), .ctrl(ctrl), .imm(imm)
    );

    rv32_regfile regfile_unit (
        .clk(clk), .rst_n(rst_n),
        .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rs1_value(rs1_value), .rs2_value(rs2_value),
        .wb_en(wb_en), .rd_write(ctrl.rd_write), .rd(ctrl.rd), .rd_value(result)
    );

    rv32_alu alu_unit (
        .clk(clk), .rst_n(rst_n),
        .exec_en(exec_en), .ctrl(ctrl), .pc(pc), .imm(imm),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .result(result), .target(target), .taken(taken)
    );

    always_comb begin
        imem_addr    = pc;    // The bench answers within the fetch cycle.
        retire_write = wb_en && ctrl.rd_write && (ctrl.rd != 5'd0);
        trace.valid  = wb_en;
        trace.rd     = retire_write ? ctrl.rd : 5'd0;
        trace.value  = retire_write ? result : '0;
        trace.pc     = pc;    // Still the retiring instruction's address.
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (retire_write && ctrl.rd == 5'd31) begin
            leds <= result[7:0];    // Low byte of each write to x31.
        end
    end

endmodule

// File: bench/rv32_asserts.sv
`timescale 1ns/10ps

module rv32_asserts (
    input logic            clk,
    input logic            rst_n,
    input rv32_pkg::step_e state,
    input logic            fetch_en,
    input logic            exec_en,
    input logic            wb_en
);
    import rv32_pkg::*;

    int error_count = 0;    // Count of failed assertions.

    fetch_to_exec: assert property (@(posedge clk) disable iff (!rst_n)
        state == step_fetch |=> state == step_exec)
    else begin
        $error("Control left step_fetch for a state other than step_exec.");
        error_count++;
    end

    exec_to_wb: assert property (@(posedge clk) disable iff (!rst_n)
        state == step_exec |=> state == step_wb)
    else begin
        $error("Control left step_exec for a state other than step_wb.");
        error_count++;
    end

    wb_to_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        state == step_wb |=> state == step_fetch)
    else begin
        $error("Control left step_wb for a state other than step_fetch.");
        error_count++;
    end

    // Exactly one step strobe in every cycle.
    one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot({fetch_en, exec_en, wb_en}))
    else begin
        $error("More or fewer than one step strobe is high.");
        error_count++;
    end

    // The first cycle out of reset is a fetch with the later strobes quiet.
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> state == step_fetch && !exec_en && !wb_en)
    else begin
        $error("Control did not start in step_fetch with exec and wb strobes low.");
        error_count++;
    end

endmodule

bind rv32_control rv32_asserts step_checks (
    .clk(clk), .rst_n(rst_n), .state(state),
    .fetch_en(fetch_en), .exec_en(exec_en), .wb_en(wb_en)
);

// File: bench/rv32_tb.sv
`timescale 1ns/10ps

module rv32_tb;
    import rv32_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    wb_trace_t   trace;
    logic [7:0]  leds;

    logic [31:0] rom [256];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [7:0]  exp_leds;

    rv32 rv32_inst (
        .clk(clk), .rst_n(rst_n), .imem_data(imem_data),
        .imem_addr(imem_addr), .trace(trace), .leds(leds)
    );

    always #20 clk = ~clk;

    assign imem_data = rom[imem_addr[9:2]];    // Word index wraps every 1 KiB.

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    always @(negedge clk) begin
        if (rv32_inst.control_unit.step_checks.error_count != 0) begin
            abort_run("A control FSM assertion failed.");
        end
    end

    task automatic check_trace(input wb_trace_t got, input wb_trace_t want);
        if (got !== want) begin
            abort_run($sformatf(
                "FAIL trace: got valid=%h rd=%h value=%h pc=%h, want valid=%h rd=%h value=%h pc=%h",
                got.valid, got.rd, got.value, got.pc,
                want.valid, want.rd, want.value, want.pc));
        end
    endtask

    task automatic check_leds(input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAIL leds: got %h, want %h", got, want));
        end
    endtask

    task automatic check_addr(input logic [xlen-1:0] got, input logic [xlen-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAIL imem_addr: got %h, want %h", got, want));
        end
    endtask

    // One random instruction from the subset, with a fifth of the writes aimed at x31.
    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] b_off;
        logic [20:0] j_off;
        int          kind;
        kind  = $urandom_range(0, 17);
        rd    = ($urandom_range(0, 4) == 0) ? 5'd31 : 5'($urandom_range(0, 31));
        rs1   = 5'($urandom_range(0, 31));
        rs2   = 5'($urandom_range(0, 31));
        b_off = 13'((int'($urandom_range(0, 63)) - 32) * 4);
        j_off = 21'((int'($urandom_range(0, 63)) - 32) * 4);
        case (kind)
            0:  return {7'b0000000, rs2, rs1, 3'b000, rd, op_reg};    // ADD.
            1:  return {7'b0100000, rs2, rs1, 3'b000, rd, op_reg};    // SUB.
            2:  return {7'b0000000, rs2, rs1, 3'b111, rd, op_reg};
            3:  return {7'b0000000, rs2, rs1, 3'b110, rd, op_reg};
            4:  return {7'b0000000, rs2, rs1, 3'b100, rd, op_reg};
            5:  return {7'b0000000, rs2, rs1, 3'b010, rd, op_reg};
            6:  return {7'b0000000, rs2, rs1, 3'b001, rd, op_reg};
            7:  return {7'b0000000, rs2, rs1, 3'b101, rd, op_reg};
            8:  return {12'($urandom), rs1, 3'b000, rd, op_imm};
            9:  return {12'($urandom), rs1, 3'b111, rd, op_imm};
            10: return {12'($urandom), rs1, 3'b110, rd, op_imm};
            11: return {12'($urandom), rs1, 3'b100, rd, op_imm};
            12: return {12'($urandom), rs1, 3'b010, rd, op_imm};
            13: return {20'($urandom), rd, op_lui};
            14: return {b_off[12], b_off[10:5], rs2, rs1, 3'b000, b_off[4:1], b_off[11], op_branch};
            15: return {b_off[12], b_off[10:5], rs2, rs1, 3'b001, b_off[4:1], b_off[11], op_branch};
            16: return {j_off[20], j_off[10:1], j_off[11], j_off[19:12], rd, op_jal};
            default: return {25'($urandom), 7'b0000011};    // A load, outside the subset.
        endcase
    endfunction

    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs the instruction at pc on the model and gives the trace it should retire with.
    task automatic model_step(input logic [31:0] pc, output wb_trace_t want,
                              output logic [31:0] next_pc);
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        logic [4:0]  rd;
        logic        write;
        word    = rom[pc[9:2]];
        rd      = word[11:7];
        a       = model_regs[word[19:15]];
        b       = model_regs[word[24:20]];
        value   = '0;
        write   = 1'b1;
        next_pc = pc + 32'd4;
        case (word[6:0])
            op_reg: value = model_alu(word[14:12], word[30], a, b);
            op_imm: value = model_alu(word[14:12], 1'b0, a, {{20{word[31]}}, word[31:20]});
            op_lui: value = {word[31:12], 12'b0};
            op_jal: begin
                value   = pc + 32'd4;
                next_pc = pc + {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            end
            op_branch: begin
                write = 1'b0;
                if ((a == b) != word[12]) begin    // funct3 bit 0 turns BEQ into BNE.
                    next_pc = pc + {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
                end
            end
            default: write = 1'b0;
        endcase
        write       = write && (rd != 5'd0);
        want.valid  = 1'b1;
        want.rd     = write ? rd : 5'd0;
        want.value  = write ? value : '0;
        want.pc     = pc;
        if (write) begin
            model_regs[rd] = value;
        end
        if (write && rd == 5'd31) begin
            exp_leds = value[7:0];
        end
    endtask

    // Waits from a fetch cycle to the writeback of the same instruction.
    task automatic wait_trace();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!trace.valid && cycles < 10);
        if (!trace.valid) begin
            abort_run("Timed out waiting for trace.valid after ten cycles.");
        end else if (cycles != 2) begin
            abort_run($sformatf("Writeback came %0d cycles after fetch instead of 2.", cycles));
        end
    endtask

    initial begin
        wb_trace_t   want;
        logic [31:0] next_pc;
        void'($urandom(32'hb49));
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = random_instr();
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = 32'h0;
        exp_leds = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        if (trace.valid !== 1'b0) begin
            abort_run("trace.valid is not low right after reset.");
        end
        check_leds(leds, 8'h00);
        check_addr(imem_addr, model_pc);
        for (int n = 0; n < 300; n++) begin
            wait_trace();
            model_step(model_pc, want, next_pc);
            check_trace(trace, want);
            model_pc = next_pc;
            @(negedge clk);    // LEDs follow one cycle after writeback.
            check_leds(leds, exp_leds);
            check_addr(imem_addr, model_pc);
        end
        if (rv32_inst.control_unit.step_checks.error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Control FSM assertions failed during the run.");
            $display("Finished with errors");
            $fatal(1, "Simulation stopped on assertion failures.");
        end
    end

endmodule

// File: src.f
logic/rv32_pkg.sv
logic/rv32_control.sv
logic/rv32_pc.sv
logic/rv32_decode.sv
logic/rv32_regfile.sv
logic/rv32_alu.sv
logic/rv32.sv
bench/rv32_asserts.sv
bench/rv32_tb.sv
